// File: div_vectors.txt
// columns: clear, dividend, divisor, status (0 ok, 1 div_zero, 2 overflow),
// approximate quotient, approximate remainder, exact quotient; all hex
0 0000 01 0 15 00 00
0 0064 0A 0 07 0A 0A
0 1234 00 1 FF FF 00
0 0000 80 0 00 00 00
0 7F00 80 0 FD 00 FE
0 0500 05 2 FF FF 00
0 4000 80 0 80 00 80
0 00FF FF 0 01 00 01
0 0000 00 1 FF FF 00
0 1234 40 0 47 00 48
0 0100 02 0 95 2A 80
0 FFFF FE 2 FF FF 00
0 0064 0A 0 07 0A 0A
0 0100 01 2 FF FF 00
0 1234 40 0 47 00 48
// statistics clear, the other columns are unused
1 0000 00 0 00 00 00
0 0000 80 0 00 00 00
0 0064 0A 0 07 0A 0A
0 0000 00 1 FF FF 00
0 00FF FF 0 01 00 01

// File: sim.f
div_types_pkg.sv
div_stats_pkg.sv
div_operand_stage.sv
div_array_stage.sv
div_error_monitor.sv
div_unit_top.sv
div_unit_asserts.sv
tb_clock_gen.sv
tb_div_unit.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_div_unit
FILELIST    ?= sim.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
FAIL_MSG    ?= ERRORS FOUND
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_div_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_div_unit;

  localparam int num_vec        = 20;
  localparam int fields         = 7;   // words per line of the vector file
  localparam int timeout_margin = 20;
  localparam int max_cycles     = num_vec + timeout_margin;

  typedef struct packed {
    logic [31:0] issue_cycle;  // cycle count when in_valid was driven
    logic [1:0]  status;
    logic [7:0]  q;
    logic [7:0]  r;
  } exp_res_t;

  logic                      clk;
  logic                      arst_n;
  logic                      in_valid;
  logic [15:0]               n;
  logic [7:0]                d;
  logic                      stats_clear;
  div_types_pkg::div_res_t   res;
  div_stats_pkg::div_stats_t stats;

  logic [15:0] vec_mem [0:num_vec*fields-1];
  exp_res_t    exp_q [$];
  logic [31:0] cycle_count = '0;
  int          error_count = 0;
  int          check_count = 0;
  int          test_count  = 0;

  // statistics the DUT should hold, built from the vector file
  logic [15:0] exp_samples;
  logic [15:0] exp_mismatches;
  logic [7:0]  exp_max_err;

  tb_clock_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  div_unit_top #(
    .approx_tri (6)
  ) u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .n           (n),
    .d           (d),
    .stats_clear (stats_clear),
    .res         (res),
    .stats       (stats)
  );

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    check_count++;
    if (exp !== got) begin
      $display("ERR %s exp %0h got %0h", name, exp, got);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    int errs;
    errs = error_count - errors_before;
    test_count++;
    $display("test %s: %s (%0d errors)", name, (errs == 0) ? "pass" : "fail", errs);
  endtask

  task automatic expect_idle();
    compare_value("res.valid", 32'd0, 32'(res.valid));
    compare_value("stats.sample_count", 32'd0, 32'(stats.sample_count));
    compare_value("stats.mismatch_count", 32'd0, 32'(stats.mismatch_count));
    compare_value("stats.max_q_err", 32'd0, 32'(stats.max_q_err));
  endtask

  task automatic verify_stats();
    compare_value("stats.sample_count", 32'(exp_samples), 32'(stats.sample_count));
    compare_value("stats.mismatch_count", 32'(exp_mismatches), 32'(stats.mismatch_count));
    compare_value("stats.max_q_err", 32'(exp_max_err), 32'(stats.max_q_err));
  endtask

  // one request per falling edge, expected result queued with its issue cycle
  task automatic drive_vector(input int idx);
    exp_res_t   e;
    logic [7:0] exact_q;
    logic [7:0] q_err;
    int         base;
    base = idx * fields;
    @(negedge clk);
    in_valid      = 1'b1;
    n             = vec_mem[base + 1];
    d             = vec_mem[base + 2][7:0];
    e.issue_cycle = cycle_count;
    e.status      = vec_mem[base + 3][1:0];
    e.q           = vec_mem[base + 4][7:0];
    e.r           = vec_mem[base + 5][7:0];
    exact_q       = vec_mem[base + 6][7:0];
    exp_q.push_back(e);
    if (e.status == 2'd0) begin
      q_err = (e.q >= exact_q) ? (e.q - exact_q) : (exact_q - e.q);
      exp_samples = exp_samples + 16'd1;
      if (q_err != 8'd0) begin
        exp_mismatches = exp_mismatches + 16'd1;
      end
      if (q_err > exp_max_err) begin
        exp_max_err = q_err;
      end
    end
  endtask

  // returns on the falling edge one cycle after the last result
  task automatic drain_results();
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic pulse_clear();
    @(negedge clk);
    stats_clear = 1'b1;
    @(negedge clk);
    stats_clear = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 32'd1;
    if (cycle_count >= 32'(max_cycles)) begin
      $display("timeout after %0d cycles with %0d results never seen",
               cycle_count, exp_q.size());
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // results are stable between edges, so they are sampled on the falling edge
  always @(negedge clk) begin
    exp_res_t e;
    if (arst_n && res.valid) begin
      if (exp_q.size() == 0) begin
        $display("result appeared with no request pending at cycle %0d", cycle_count);
        error_count++;
      end else begin
        e = exp_q.pop_front();
        compare_value("res latency", 32'd2, cycle_count - e.issue_cycle);
        compare_value("res.status", 32'(e.status), 32'(res.status));
        compare_value("res.q", 32'(e.q), 32'(res.q));
        compare_value("res.r", 32'(e.r), 32'(res.r));
      end
    end
  end

  initial begin
    int mark;
    in_valid       = 1'b0;
    n              = '0;
    d              = '0;
    stats_clear    = 1'b0;
    exp_samples    = '0;
    exp_mismatches = '0;
    exp_max_err    = '0;
    $readmemh("div_vectors.txt", vec_mem);

    mark = error_count;
    @(negedge clk);
    while (!arst_n) begin
      expect_idle();
      @(negedge clk);
    end
    expect_idle();  // first falling edge after release
    report_test("reset", mark);

    mark = error_count;
    for (int i = 0; i < num_vec; i++) begin
      if (vec_mem[i * fields][0]) begin
        // a clear line closes the first batch
        drain_results();
        report_test("results before clear", mark);
        mark = error_count;
        verify_stats();
        report_test("statistics before clear", mark);
        mark = error_count;
        pulse_clear();
        expect_idle();
        report_test("clear", mark);
        exp_samples    = '0;
        exp_mismatches = '0;
        exp_max_err    = '0;
        mark = error_count;
      end else begin
        drive_vector(i);
      end
    end
    drain_results();
    report_test("results after clear", mark);
    mark = error_count;
    verify_stats();
    report_test("statistics after clear", mark);

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 2,  // 4 ns clock
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset starts after time 0 so the flops see a real falling edge
  initial begin
    arst_n = 1'b1;
    #1;
    arst_n = 1'b0;
    #(2 * half_period * reset_cycles);
    arst_n = 1'b1;  // released between clock edges
  end

endmodule

`default_nettype wire

// File: div_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module div_unit_asserts (
  input wire logic                       clk,
  input wire logic                       arst_n,
  input wire logic                       in_valid,
  input wire div_types_pkg::div_res_t    res,
  input wire div_stats_pkg::div_stats_t  stats
);

  // every request produces a result exactly two edges later
  a_result_follows_request: assert property (
    @(posedge clk) disable iff (!arst_n) $past(in_valid, 2) |-> res.valid
  ) else $error("result missing two cycles after a request");

  a_no_stray_result: assert property (
    @(posedge clk) disable iff (!arst_n) res.valid |-> $past(in_valid, 2)
  ) else $error("result without a request two cycles earlier");

  // faulted requests carry the fixed pattern in both fields
  a_fault_pattern: assert property (
    @(posedge clk) disable iff (!arst_n)
      (res.valid && (res.status != div_types_pkg::st_ok)) |->
        ((res.q == div_types_pkg::fault_value) && (res.r == div_types_pkg::fault_value))
  ) else $error("faulted result does not carry 0xff");

  a_quiet_in_reset: assert property (
    @(posedge clk) !arst_n |-> (!res.valid && (stats == '0))
  ) else $error("result or statistics active during reset");

endmodule

bind div_unit_top div_unit_asserts u_asserts (
  .clk      (clk),
  .arst_n   (arst_n),
  .in_valid (in_valid),
  .res      (res),
  .stats    (stats)
);

`default_nettype wire

// File: div_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module div_unit_top #(
  parameter int approx_tri = 6  // 0 turns the array into an exact divider
) (
  input  wire logic                              clk,
  input  wire logic                              arst_n,
  input  wire logic                              in_valid,
  input  wire logic [div_types_pkg::n_width-1:0] n,
  input  wire logic [div_types_pkg::d_width-1:0] d,
  input  wire logic                              stats_clear,
  output div_types_pkg::div_res_t                res,
  output div_stats_pkg::div_stats_t              stats
);

  div_types_pkg::div_op_t op_q;  // registered and classified request

  div_operand_stage u_operand (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .n        (n),
    .d        (d),
    .op_q     (op_q)
  );

  // result two cycles after in_valid, one per cycle, no stall
  div_array_stage #(
    .approx_tri (approx_tri)
  ) u_array (
    .clk    (clk),
    .arst_n (arst_n),
    .op_q   (op_q),
    .res    (res)
  );

  div_error_monitor u_monitor (
    .clk         (clk),
    .arst_n      (arst_n),
    .stats_clear (stats_clear),
    .op_q        (op_q),
    .res         (res),
    .stats       (stats)
  );

endmodule

`default_nettype wire

// File: div_error_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module div_error_monitor (
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic                      stats_clear,
  input  wire div_types_pkg::div_op_t    op_q,
  input  wire div_types_pkg::div_res_t   res,
  output div_stats_pkg::div_stats_t      stats
);

  localparam int nw = div_types_pkg::n_width;
  localparam int dw = div_types_pkg::d_width;

  localparam logic [div_stats_pkg::cnt_width-1:0] cnt_step = 1;

  logic [nw-1:0]                      exact_full;
  logic [dw-1:0]                      exact_q;   // aligned with res
  logic [div_stats_pkg::err_width-1:0] q_err;
  logic                               take;
  div_stats_pkg::div_stats_t          stats_q;

  // reference divide, a zero divisor is steered away and never counted anyway
  always_comb begin
    if (op_q.d == '0) begin
      exact_full = '0;
    end else begin
      exact_full = op_q.n / {{(nw - dw){1'b0}}, op_q.d};
    end
  end

  // same one-cycle delay as the array stage
  always_ff @(posedge clk) begin
    if (op_q.valid) begin
      exact_q <= exact_full[dw-1:0];
    end
  end

  assign take  = res.valid && (res.status == div_types_pkg::st_ok);
  assign q_err = (res.q >= exact_q) ? (res.q - exact_q) : (exact_q - res.q);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stats_q <= '0;
    end else if (stats_clear) begin
      stats_q <= '0;  // a result landing together with the clear is lost
    end else if (take) begin
      if (stats_q.sample_count != div_stats_pkg::cnt_max) begin
        stats_q.sample_count <= stats_q.sample_count + cnt_step;
      end
      if ((q_err != '0) && (stats_q.mismatch_count != div_stats_pkg::cnt_max)) begin
        stats_q.mismatch_count <= stats_q.mismatch_count + cnt_step;
      end
      if (q_err > stats_q.max_q_err) begin
        stats_q.max_q_err <= q_err;
      end
    end
  end

  assign stats = stats_q;

endmodule

`default_nettype wire

// File: div_array_stage.sv
`timescale 1ns/10ps
`default_nettype none

module div_array_stage #(
  parameter int approx_tri = 0  // cells with row + column below this are approximate
) (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire div_types_pkg::div_op_t   op_q,
  output div_types_pkg::div_res_t       res
);

  localparam int nw = div_types_pkg::n_width;
  localparam int dw = div_types_pkg::d_width;

  logic [dw-1:0] row_rem [0:dw-1];  // partial remainder leaving each quotient row
  logic [dw-1:0] quo;

  logic                       res_valid;
  logic [dw-1:0]              res_q;
  logic [dw-1:0]              res_r;
  div_types_pkg::div_status_e res_status;

  // row dw-1 resolves the top quotient bit first, row 0 leaves the remainder
  for (genvar i = 0; i < dw; i++) begin : g_row
    logic [dw-1:0] x;     // minuend bits seen by the cells of this row
    logic          top;   // bit shifted out above the divisor width
    logic [dw:0]   b;     // borrow ripple from column 0 upwards
    logic [dw-1:0] diff;

    if (i == dw - 1) begin : g_first
      assign x   = op_q.n[nw-2:dw-1];
      assign top = op_q.n[nw-1];
    end else begin : g_next
      assign x   = {row_rem[i+1][dw-2:0], op_q.n[i]};  // shift in the next dividend bit
      assign top = row_rem[i+1][dw-1];
    end

    assign b[0] = 1'b0;

    for (genvar j = 0; j < dw; j++) begin : g_cell
      if (i + j < approx_tri) begin : g_approx
        // cheap cell, the borrow only toggles and the difference needs an incoming borrow
        assign diff[j] = b[j] & (x[j] ^ op_q.d[j]);
        assign b[j+1]  = ~b[j];
      end else begin : g_exact
        assign diff[j] = x[j] ^ op_q.d[j] ^ b[j];
        assign b[j+1]  = (~x[j] & op_q.d[j]) | (~(x[j] ^ op_q.d[j]) & b[j]);
      end
    end

    // subtraction is kept when the shifted-out bit is set or no final borrow occurred
    assign quo[i]     = top | ~b[dw];
    assign row_rem[i] = quo[i] ? diff : x;  // restoring step passes x through
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= op_q.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_q.valid) begin
      res_status <= op_q.status;
      if (op_q.status == div_types_pkg::st_ok) begin
        res_q <= quo;
        res_r <= row_rem[0];
      end else begin
        res_q <= div_types_pkg::fault_value;
        res_r <= div_types_pkg::fault_value;
      end
    end
  end

  assign res = '{valid: res_valid, q: res_q, r: res_r, status: res_status};

endmodule

`default_nettype wire

// File: div_operand_stage.sv
`timescale 1ns/10ps
`default_nettype none

module div_operand_stage (
  input  wire logic                                clk,
  input  wire logic                                arst_n,
  input  wire logic                                in_valid,
  input  wire logic [div_types_pkg::n_width-1:0]   n,
  input  wire logic [div_types_pkg::d_width-1:0]   d,
  output div_types_pkg::div_op_t                   op_q
);

  logic                              valid_q;
  logic [div_types_pkg::n_width-1:0] n_q;
  logic [div_types_pkg::d_width-1:0] d_q;
  div_types_pkg::div_status_e        status_d;
  div_types_pkg::div_status_e        status_q;

  // a zero divisor wins over overflow, the upper byte compare would be meaningless
  always_comb begin
    if (d == '0) begin
      status_d = div_types_pkg::st_div_zero;
    end else if (n[div_types_pkg::n_width-1 -: div_types_pkg::d_width] >= d) begin
      status_d = div_types_pkg::st_overflow;
    end else begin
      status_d = div_types_pkg::st_ok;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;  // drops back to 0 when no request arrives
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      n_q      <= n;
      d_q      <= d;
      status_q <= status_d;
    end
  end

  assign op_q = '{valid: valid_q, n: n_q, d: d_q, status: status_q};

endmodule

`default_nettype wire

// File: div_stats_pkg.sv
`default_nettype none

package div_stats_pkg;

  localparam int cnt_width = 16;  // sample and mismatch counters
  localparam int err_width = 8;   // largest quotient error seen

  // counters stop here instead of wrapping
  localparam logic [cnt_width-1:0] cnt_max = '1;

  typedef struct packed {
    logic [cnt_width-1:0] sample_count;    // ok results seen
    logic [cnt_width-1:0] mismatch_count;  // ok results with q off the exact quotient
    logic [err_width-1:0] max_q_err;
  } div_stats_t;

endpackage

`default_nettype wire

// File: div_types_pkg.sv
`default_nettype none

package div_types_pkg;

  localparam int n_width = 16;  // dividend
  localparam int d_width = 8;   // divisor, quotient and remainder

  // q and r carry this pattern whenever a request is faulted
  localparam logic [d_width-1:0] fault_value = '1;

  typedef enum logic [1:0] {
    st_ok       = 2'd0,
    st_div_zero = 2'd1,  // divisor was zero
    st_overflow = 2'd2   // quotient would not fit in d_width bits
  } div_status_e;

  // one request after the operand stage, status already decided
  typedef struct packed {
    logic               valid;
    logic [n_width-1:0] n;
    logic [d_width-1:0] d;
    div_status_e        status;
  } div_op_t;

  typedef struct packed {
    logic               valid;  // single-cycle pulse per result
    logic [d_width-1:0] q;
    logic [d_width-1:0] r;
    div_status_e        status;
  } div_res_t;

endpackage

`default_nettype wire
